/* files.f */
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_btb.sv
rtl/fetch_imem.sv
rtl/fetch_if1.sv
rtl/fetch_top.sv
sim/fetch_tb.sv

/* rtl/fetch_btb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_btb
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] pc,
  input  logic        br_update,
  input  logic [31:0] br_pc,
  input  logic [31:0] br_target,
  input  logic        br_taken,
  output logic [31:0] pred_next_pc,
  output logic [3:0]  slot_mask,
  output logic [3:0]  jump_mask
);

  logic                 ent_valid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] ent_tag    [BTB_ENTRIES];
  logic [SLOT_W-1:0]    ent_slot   [BTB_ENTRIES];
  logic [31:0]          ent_target [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic [SLOT_W-1:0]    rd_off;
  logic [SLOT_W-1:0]    rd_slot;
  logic [31:0]          group_base;
  logic                 hit;
  logic                 take;

  logic [BTB_IDX_W-1:0] up_idx;
  logic [BTB_TAG_W-1:0] up_tag;
  logic [SLOT_W-1:0]    up_slot;
  logic                 up_match;

  assign rd_idx     = pc[GROUP_OFS_W +: BTB_IDX_W];
  assign rd_tag     = pc[31 -: BTB_TAG_W];
  assign rd_off     = pc[2 +: SLOT_W];  // first slot fetched in this group.
  assign rd_slot    = ent_slot[rd_idx];
  assign group_base = pc & ~32'(GROUP_BYTES - 1);

  assign hit  = ent_valid[rd_idx] && (ent_tag[rd_idx] == rd_tag);
  assign take = hit && (rd_slot >= rd_off);  // a branch behind the entry point is skipped.

  always_comb begin
    for (int i = 0; i < GROUP_SLOTS; i++) begin
      slot_mask[i] = (SLOT_W'(i) >= rd_off) && (!take || SLOT_W'(i) <= rd_slot);
      jump_mask[i] = take && (SLOT_W'(i) == rd_slot);
    end
  end

  assign pred_next_pc = take ? ent_target[rd_idx] : group_base + 32'(GROUP_BYTES);

  assign up_idx   = br_pc[GROUP_OFS_W +: BTB_IDX_W];
  assign up_tag   = br_pc[31 -: BTB_TAG_W];
  assign up_slot  = br_pc[2 +: SLOT_W];
  assign up_match = ent_valid[up_idx] && (ent_tag[up_idx] == up_tag) &&
                    (ent_slot[up_idx] == up_slot);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        ent_valid[i] <= 1'b0;
      end
    end else if (br_update) begin
      if (br_taken) begin
        ent_valid[up_idx] <= 1'b1;
      end else if (up_match) begin
        ent_valid[up_idx] <= 1'b0;  // only drop the entry for this very branch.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (br_update && br_taken) begin
      ent_tag[up_idx]    <= up_tag;
      ent_slot[up_idx]   <= up_slot;
      ent_target[up_idx] <= br_target;
    end
  end

  a_jump_in_mask: assert property (@(posedge clk) disable iff (rst)
    $onehot0(jump_mask) && (jump_mask & ~slot_mask) == 4'b0000);

endmodule

`default_nettype wire

/* rtl/fetch_if1.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_if1
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  logic        if0_valid,
  input  logic [31:0] if0_pc,
  input  logic [3:0]  if0_mask,
  input  logic [3:0]  if0_jump,
  input  logic        if0_excp,
  input  excp_code_e  if0_ecode,
  input  logic        data_ok,
  input  logic [31:0] rdata0,
  input  logic [31:0] rdata1,
  input  logic [31:0] rdata2,
  input  logic [31:0] rdata3,
  input  logic        dec_ready,
  output logic        if1_ready,
  output logic        dec_valid,
  output logic [31:0] dec_pc,
  output logic [3:0]  dec_mask,
  output logic [3:0]  dec_jump,
  output logic [31:0] dec_inst0,
  output logic [31:0] dec_inst1,
  output logic [31:0] dec_inst2,
  output logic [31:0] dec_inst3,
  output logic        dec_excp,
  output excp_code_e  dec_ecode
);

  logic kill;
  logic capture;
  logic consume;

  assign consume = dec_valid & dec_ready;

  // a new request lands here two edges later, so the register must be free after this edge.
  assign if1_ready = ~if0_valid & (~dec_valid | dec_ready);

  // exception packets carry no memory data.
  assign capture = if0_valid & ~kill & (if0_excp | data_ok);

  always_ff @(posedge clk) begin
    if (rst) begin
      kill      <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      kill <= redirect;  // data returning right after a redirect is stale.
      if (redirect) begin
        dec_valid <= 1'b0;
      end else if (capture) begin
        dec_valid <= 1'b1;
      end else if (consume) begin
        dec_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      dec_pc    <= if0_pc;
      dec_mask  <= if0_excp ? 4'b0000 : if0_mask;
      dec_jump  <= if0_excp ? 4'b0000 : if0_jump;
      dec_inst0 <= if0_excp ? 32'h0 : rdata0;
      dec_inst1 <= if0_excp ? 32'h0 : rdata1;
      dec_inst2 <= if0_excp ? 32'h0 : rdata2;
      dec_inst3 <= if0_excp ? 32'h0 : rdata3;
      dec_excp  <= if0_excp;
      dec_ecode <= if0_ecode;
    end
  end

  // a fetched group always holds its entry slot, only an exception packet is empty.
  a_excp_iff_no_mask: assert property (@(posedge clk) disable iff (rst)
    dec_valid |-> dec_excp == (dec_mask == 4'b0000));

  // pc_gen only requests when this register will have room, so nothing is overwritten.
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    capture && !redirect |-> !dec_valid || dec_ready);

endmodule

`default_nettype wire

/* rtl/fetch_imem.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_imem
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  logic [31:0] req_addr,
  input  logic        mem_stall,
  output logic        addr_ok,
  output logic        data_ok,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  output logic [31:0] rdata3
);

  logic [31:0]        mem [IMEM_WORDS];
  logic [IMEM_AW-1:0] idx;
  logic [31:0]        hi_bits;
  logic               accept;

  // the array holds the image of the low window, each word the complement of its address.
  initial begin
    for (int i = 0; i < IMEM_WORDS; i++) begin
      mem[i] = ~(32'(i) << 2);
    end
  end

  assign addr_ok = req & ~mem_stall;
  assign accept  = req & addr_ok;
  assign idx     = req_addr[2 +: IMEM_AW];

  // bits above the window flip the stored ones, so every alias still reads ~address.
  assign hi_bits = {req_addr[31:IMEM_AW+2], {(IMEM_AW + 2){1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      data_ok <= 1'b0;
    end else begin
      data_ok <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata0 <= mem[idx] ^ hi_bits;
      rdata1 <= mem[idx + IMEM_AW'(1)] ^ hi_bits;
      rdata2 <= mem[idx + IMEM_AW'(2)] ^ hi_bits;
      rdata3 <= mem[idx + IMEM_AW'(3)] ^ hi_bits;
    end
  end

  // returned words read as the complement of the accepted group address.
  a_data_rule: assert property (@(posedge clk) disable iff (rst)
    data_ok |-> rdata0 == ~$past(req_addr) && rdata3 == ~($past(req_addr) + 32'd12));

endmodule

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        addr_ok,
  input  logic        if1_ready,
  input  logic [31:0] pred_next_pc,
  input  logic [3:0]  slot_mask,
  input  logic [3:0]  jump_mask,
  output logic        req,
  output logic [31:0] req_addr,
  output logic [31:0] pc,
  output logic        if0_valid,
  output logic [31:0] if0_pc,
  output logic [3:0]  if0_mask,
  output logic [3:0]  if0_jump,
  output logic        if0_excp,
  output excp_code_e  if0_ecode
);

  logic [31:0] pc_q;
  logic        fault_sent;
  logic        is_adef;
  logic        accept;
  logic        fault_go;

  assign pc       = pc_q;
  assign is_adef  = |pc_q[1:0];  // instructions are word aligned.
  assign req      = ~rst & if1_ready & ~is_adef & ~fault_sent;
  assign req_addr = pc_q & ~32'(GROUP_BYTES - 1);
  assign accept   = req & addr_ok;

  // a misaligned pc sends one exception packet in place of a request.
  assign fault_go = is_adef & ~fault_sent & if1_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (redirect) begin
      pc_q <= redirect_pc;
    end else if (accept) begin
      pc_q <= pred_next_pc;  // stalls and faults hold the pc.
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      fault_sent <= 1'b0;
      if0_valid  <= 1'b0;
    end else begin
      fault_sent <= fault_sent | fault_go;
      if0_valid  <= accept | fault_go;  // if1 always takes it the next cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (accept || fault_go) begin
      if0_pc    <= pc_q;
      if0_mask  <= slot_mask;
      if0_jump  <= jump_mask;
      if0_excp  <= fault_go;
      if0_ecode <= fault_go ? EXCP_ADEF : EXCP_NONE;
    end
  end

  // a group without a predicted jump falls through to the next group.
  a_fall_through: assert property (@(posedge clk) disable iff (rst)
    accept && jump_mask == 4'b0000 |-> pred_next_pc == req_addr + 32'(GROUP_BYTES));

endmodule

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // reset vector of the core.
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  localparam int GROUP_SLOTS = 4;
  localparam int GROUP_BYTES = 16;
  localparam int GROUP_OFS_W = $clog2(GROUP_BYTES);  // byte offset bits inside a group.
  localparam int SLOT_W      = $clog2(GROUP_SLOTS);

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W   = 32 - GROUP_OFS_W - BTB_IDX_W;  // pc bits above the index.

  localparam int IMEM_WORDS = 1024;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);

  // LoongArch ecode values, only the fetch side ones.
  typedef enum logic [5:0] {
    EXCP_NONE = 6'h00,
    EXCP_ADEF = 6'h08
  } excp_code_e;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        br_update,
  input  logic [31:0] br_pc,
  input  logic [31:0] br_target,
  input  logic        br_taken,
  input  logic        mem_stall,
  input  logic        dec_ready,
  output logic        dec_valid,
  output logic [31:0] dec_pc,
  output logic [3:0]  dec_mask,
  output logic [3:0]  dec_jump,
  output logic [31:0] dec_inst0,
  output logic [31:0] dec_inst1,
  output logic [31:0] dec_inst2,
  output logic [31:0] dec_inst3,
  output logic        dec_excp,
  output excp_code_e  dec_ecode
);

  logic        req;
  logic [31:0] req_addr;
  logic        addr_ok;
  logic        data_ok;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] rdata3;
  logic [31:0] pc;
  logic [31:0] pred_next_pc;
  logic [3:0]  slot_mask;
  logic [3:0]  jump_mask;
  logic        if1_ready;
  logic        if0_valid;
  logic [31:0] if0_pc;
  logic [3:0]  if0_mask;
  logic [3:0]  if0_jump;
  logic        if0_excp;
  excp_code_e  if0_ecode;

  fetch_pc_gen i_fetch_pc_gen (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .addr_ok      (addr_ok),
    .if1_ready    (if1_ready),
    .pred_next_pc (pred_next_pc),
    .slot_mask    (slot_mask),
    .jump_mask    (jump_mask),
    .req          (req),
    .req_addr     (req_addr),
    .pc           (pc),
    .if0_valid    (if0_valid),
    .if0_pc       (if0_pc),
    .if0_mask     (if0_mask),
    .if0_jump     (if0_jump),
    .if0_excp     (if0_excp),
    .if0_ecode    (if0_ecode)
  );

  fetch_btb i_fetch_btb (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .br_update    (br_update),
    .br_pc        (br_pc),
    .br_target    (br_target),
    .br_taken     (br_taken),
    .pred_next_pc (pred_next_pc),
    .slot_mask    (slot_mask),
    .jump_mask    (jump_mask)
  );

  fetch_imem i_fetch_imem (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_addr  (req_addr),
    .mem_stall (mem_stall),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .rdata3    (rdata3)
  );

  fetch_if1 i_fetch_if1 (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .if0_valid (if0_valid),
    .if0_pc    (if0_pc),
    .if0_mask  (if0_mask),
    .if0_jump  (if0_jump),
    .if0_excp  (if0_excp),
    .if0_ecode (if0_ecode),
    .data_ok   (data_ok),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .rdata3    (rdata3),
    .dec_ready (dec_ready),
    .if1_ready (if1_ready),
    .dec_valid (dec_valid),
    .dec_pc    (dec_pc),
    .dec_mask  (dec_mask),
    .dec_jump  (dec_jump),
    .dec_inst0 (dec_inst0),
    .dec_inst1 (dec_inst1),
    .dec_inst2 (dec_inst2),
    .dec_inst3 (dec_inst3),
    .dec_excp  (dec_excp),
    .dec_ecode (dec_ecode)
  );

endmodule

`default_nettype wire

/* sim/fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
;

  typedef enum logic [1:0] {ACT_NONE, ACT_REDIRECT, ACT_UPDATE} act_e;

  typedef struct packed {
    act_e        act;
    logic [31:0] addr;       // redirect pc or branch pc.
    logic [31:0] target;
    logic        taken;
    logic [15:0] count;      // packets to collect after the action.
    logic [7:0]  stall_pct;
    logic [7:0]  hold_pct;   // chance that dec_ready is low.
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        br_update;
  logic [31:0] br_pc;
  logic [31:0] br_target;
  logic        br_taken;
  logic        mem_stall;
  logic        dec_ready;
  logic        dec_valid;
  logic [31:0] dec_pc;
  logic [3:0]  dec_mask;
  logic [3:0]  dec_jump;
  logic [31:0] dec_inst0;
  logic [31:0] dec_inst1;
  logic [31:0] dec_inst2;
  logic [31:0] dec_inst3;
  logic        dec_excp;
  excp_code_e  dec_ecode;

  row_t        rows [16];
  int          num_rows = 0;
  logic        table_loaded = 1'b0;
  integer      seed = 32'h1fcd;

  // model state, the expected pc and a private copy of the btb.
  logic [31:0] exp_pc;
  logic        halted;
  logic        m_valid  [16];
  logic [23:0] m_tag    [16];
  logic [1:0]  m_slot   [16];
  logic [31:0] m_target [16];

  fetch_top i_fetch_top (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .br_update   (br_update),
    .br_pc       (br_pc),
    .br_target   (br_target),
    .br_taken    (br_taken),
    .mem_stall   (mem_stall),
    .dec_ready   (dec_ready),
    .dec_valid   (dec_valid),
    .dec_pc      (dec_pc),
    .dec_mask    (dec_mask),
    .dec_jump    (dec_jump),
    .dec_inst0   (dec_inst0),
    .dec_inst1   (dec_inst1),
    .dec_inst2   (dec_inst2),
    .dec_inst3   (dec_inst3),
    .dec_excp    (dec_excp),
    .dec_ecode   (dec_ecode)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  function automatic int rand_pct();
    int r;
    r = $random(seed);
    return int'($unsigned(r) % 100);
  endfunction

  task automatic add_row(input act_e act, input logic [31:0] addr, input logic [31:0] target,
                         input logic taken, input int count, input int stall, input int hold);
    rows[num_rows].act       = act;
    rows[num_rows].addr      = addr;
    rows[num_rows].target    = target;
    rows[num_rows].taken     = taken;
    rows[num_rows].count     = 16'(count);
    rows[num_rows].stall_pct = 8'(stall);
    rows[num_rows].hold_pct  = 8'(hold);
    num_rows++;
  endtask

  // compares the packet on the dec_ outputs with the model and advances the model.
  task automatic check_packet();
    logic [31:0] base;
    logic [1:0]  off;
    logic [3:0]  idx;
    logic        take;
    logic [3:0]  mask;
    logic [3:0]  jump;
    base = exp_pc & 32'hffff_fff0;
    off  = exp_pc[3:2];
    idx  = exp_pc[7:4];
    check_value("dec_pc", exp_pc, dec_pc);
    if (exp_pc[1:0] != 2'b00) begin
      check_value("dec_excp", 32'h1, 32'(dec_excp));
      check_value("dec_ecode", 32'(EXCP_ADEF), 32'(dec_ecode));
      check_value("dec_mask", 32'h0, 32'(dec_mask));
      check_value("dec_jump", 32'h0, 32'(dec_jump));
      check_value("dec_inst0", 32'h0, dec_inst0);
      check_value("dec_inst1", 32'h0, dec_inst1);
      check_value("dec_inst2", 32'h0, dec_inst2);
      check_value("dec_inst3", 32'h0, dec_inst3);
      halted = 1'b1;  // an address error stops fetch until the next redirect.
    end else begin
      take = m_valid[idx] && m_tag[idx] == exp_pc[31:8] && m_slot[idx] >= off;
      for (int i = 0; i < 4; i++) begin
        mask[i] = i >= off && (!take || i <= m_slot[idx]);
        jump[i] = take && i == m_slot[idx];
      end
      check_value("dec_excp", 32'h0, 32'(dec_excp));
      check_value("dec_ecode", 32'(EXCP_NONE), 32'(dec_ecode));
      check_value("dec_mask", 32'(mask), 32'(dec_mask));
      check_value("dec_jump", 32'(jump), 32'(dec_jump));
      check_value("dec_inst0", ~base, dec_inst0);
      check_value("dec_inst1", ~(base + 32'd4), dec_inst1);
      check_value("dec_inst2", ~(base + 32'd8), dec_inst2);
      check_value("dec_inst3", ~(base + 32'd12), dec_inst3);
      exp_pc = take ? m_target[idx] : base + 32'd16;
    end
  endtask

  task automatic apply_action(input row_t row);
    dec_ready = 1'b0;  // nothing is consumed in the action cycle.
    mem_stall = 1'b0;
    if (row.act == ACT_REDIRECT) begin
      redirect    = 1'b1;
      redirect_pc = row.addr;
      exp_pc      = row.addr;
      halted      = 1'b0;
    end else if (row.act == ACT_UPDATE) begin
      br_update = 1'b1;
      br_pc     = row.addr;
      br_target = row.target;
      br_taken  = row.taken;
      if (row.taken) begin
        m_valid[row.addr[7:4]]  = 1'b1;
        m_tag[row.addr[7:4]]    = row.addr[31:8];
        m_slot[row.addr[7:4]]   = row.addr[3:2];
        m_target[row.addr[7:4]] = row.target;
      end else if (m_tag[row.addr[7:4]] == row.addr[31:8] &&
                   m_slot[row.addr[7:4]] == row.addr[3:2]) begin
        m_valid[row.addr[7:4]] = 1'b0;
      end
    end
    if (row.act != ACT_NONE) begin
      @(posedge clk);
      #1;
      redirect  = 1'b0;
      br_update = 1'b0;
    end
  endtask

  task automatic collect_packets(input row_t row);
    int got;
    got = 0;
    while (got < row.count) begin
      mem_stall = rand_pct() < row.stall_pct;
      dec_ready = rand_pct() >= row.hold_pct;
      if (dec_valid && dec_ready) begin  // consumed at the coming edge.
        check_packet();
        got++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_quiet(input int cycles);
    dec_ready = 1'b1;
    mem_stall = 1'b0;
    repeat (cycles) begin
      check_value("dec_valid", 32'h0, 32'(dec_valid));
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : watchdog
    int total;
    wait (table_loaded);
    total = 0;
    for (int i = 0; i < num_rows; i++) begin
      total += rows[i].count;
    end
    repeat (total * 20 + 100) @(posedge clk);
    $display("timeout, packets stopped arriving from the fetch front end");
    $display("*** FAILED ***");
    $fatal(1);
  end

  initial begin
    rst         = 1'b1;
    redirect    = 1'b0;
    redirect_pc = 32'h0;
    br_update   = 1'b0;
    br_pc       = 32'h0;
    br_target   = 32'h0;
    br_taken    = 1'b0;
    mem_stall   = 1'b0;
    dec_ready   = 1'b0;
    exp_pc      = RESET_PC;
    halted      = 1'b0;
    for (int i = 0; i < 16; i++) begin
      m_valid[i]  = 1'b0;
      m_tag[i]    = 24'h0;
      m_slot[i]   = 2'b00;
      m_target[i] = 32'h0;
    end
    add_row(ACT_NONE,     32'h0,         32'h0,         1'b0, 20,  0,  0);
    add_row(ACT_NONE,     32'h0,         32'h0,         1'b0, 200, 30, 30);
    add_row(ACT_REDIRECT, 32'h1c00_0108, 32'h0,         1'b0, 6,   0,  0);
    add_row(ACT_UPDATE,   32'h1c00_0204, 32'h1c00_0400, 1'b1, 0,   0,  0);
    add_row(ACT_REDIRECT, 32'h1c00_01f0, 32'h0,         1'b0, 6,   20, 20);
    add_row(ACT_UPDATE,   32'h1c00_0204, 32'h1c00_0400, 1'b0, 0,   0,  0);
    add_row(ACT_REDIRECT, 32'h1c00_0200, 32'h0,         1'b0, 4,   0,  0);
    add_row(ACT_REDIRECT, 32'h1c00_0302, 32'h0,         1'b0, 1,   0,  0);
    add_row(ACT_REDIRECT, 32'h1c00_0500, 32'h0,         1'b0, 8,   25, 25);
    table_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      apply_action(rows[r]);
      collect_packets(rows[r]);
      if (halted) begin
        check_quiet(30);
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
